// ==== verilog/ll_pkg.sv ====
////////////////////
// Depth is fixed at 32 entries, so pointers are 5 bits wide
// Counts need one extra bit to hold a full list
////////////////////

`default_nettype none

package ll_pkg;

  // Number of entries in the pointer RAM
  localparam int LL_DEPTH = 32;

  // Pointer width follows the depth
  localparam int LL_PTR_W = $clog2(LL_DEPTH);

  // Count width must be able to represent LL_DEPTH itself
  localparam int LL_CNT_W = $clog2(LL_DEPTH + 1);

  typedef logic [LL_PTR_W-1:0] ll_ptr_t;
  typedef logic [LL_CNT_W-1:0] ll_cnt_t;

  // One write into the pointer RAM links the old tail to the new tail
  typedef struct packed {
    logic    valid;
    ll_ptr_t addr;
    ll_ptr_t data;
  } ll_ram_wr_t;

  // Read request at the address of the head being popped
  typedef struct packed {
    logic    valid;
    ll_ptr_t addr;
  } ll_ram_rd_req_t;

  // Read return carrying the next head
  typedef struct packed {
    logic    valid;
    ll_ptr_t data;
  } ll_ram_rd_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/ll_delay_line.sv ====
////////////////////
// Stages = 0 passes input straight through in the same cycle
// Only the valid bits are cleared at reset
////////////////////

`timescale 1ns/1ns
`default_nettype none

module ll_delay_line #(
  parameter int  Stages    = 1,
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  if (Stages == 0) begin : gen_pass
    assign out_valid = in_valid;
    assign out_data  = in_data;
  end else begin : gen_pipe
    logic [Stages-1:0] valid_q;
    payload_t          data_q [Stages];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= in_valid;
        for (int i = 1; i < Stages; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    // Payload just shifts along with its valid tag
    always_ff @(posedge clk) begin
      data_q[0] <= in_data;
      for (int i = 1; i < Stages; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end

    assign out_valid = valid_q[Stages-1];
    assign out_data  = data_q[Stages-1];
  end

endmodule

`default_nettype wire

// ==== verilog/ll_ptr_ram.sv ====
////////////////////
// Contents are undefined after reset until written
// A read at an address written in the same cycle sees the new data
////////////////////

`timescale 1ns/1ns
`default_nettype none

module ll_ptr_ram import ll_pkg::*; #(
  parameter int RamReadLatency = 2
) (
  input  logic           clk,
  input  logic           rst_n,
  input  ll_ram_wr_t     wr,
  input  ll_ram_rd_req_t rd_req,
  output ll_ram_rd_rsp_t rd_rsp
);

  ll_ptr_t mem [LL_DEPTH];
  ll_ptr_t rd_data;
  logic    rsp_valid;
  ll_ptr_t rsp_data;

  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Popping the only entry while a push links it needs the bypass
  // Otherwise the stale next pointer would be returned
  always_comb begin
    if (wr.valid && (wr.addr == rd_req.addr)) begin
      rd_data = wr.data;
    end else begin
      rd_data = mem[rd_req.addr];
    end
  end

  // Read data is sampled now and delivered RamReadLatency cycles later
  ll_delay_line #(
    .Stages    (RamReadLatency),
    .payload_t (ll_ptr_t)
  ) rd_delay_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (rd_req.valid),
    .in_data   (rd_data),
    .out_valid (rsp_valid),
    .out_data  (rsp_data)
  );

  assign rd_rsp = '{valid: rsp_valid, data: rsp_data};

endmodule

`default_nettype wire

// ==== verilog/ll_sublist.sv ====
////////////////////
// Selects arrive already gated by the push and pop strobes
// A RAM return for this sub-list never coincides with a push into it while empty
////////////////////

`timescale 1ns/1ns
`default_nettype none

module ll_sublist import ll_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           push_sel,
  input  ll_ptr_t        push_ptr,
  input  logic           pop_sel,
  input  logic           rsp_sel,
  input  ll_ram_rd_rsp_t rd_rsp,
  output ll_ptr_t        head,
  output logic           head_ok,
  output logic           last,
  output ll_cnt_t        count,
  output ll_ram_wr_t     ram_wr
);

  ll_ptr_t head_q;
  ll_ptr_t tail_q;
  ll_cnt_t count_q;
  logic    head_valid_q;
  logic    is_empty;
  logic    load_from_push;
  logic    load_from_ram;
  logic    head_load;
  ll_ptr_t head_next;

  assign is_empty = (count_q == '0);

  // An empty sub-list takes the pushed pointer straight as its head
  assign load_from_push = push_sel && is_empty;
  assign load_from_ram  = rsp_sel && rd_rsp.valid;
  assign head_load      = load_from_push || load_from_ram;
  assign head_next      = load_from_push ? push_ptr : rd_rsp.data;

  // Count and head-valid flag are the control state of the sub-list
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q      <= '0;
      head_valid_q <= 1'b0;
    end else begin
      count_q      <= count_q + ll_cnt_t'(push_sel) - ll_cnt_t'(pop_sel);
      head_valid_q <= (head_valid_q && !pop_sel) || head_load;
    end
  end

  // Head loads from a push into an empty sub-list or from a RAM return
  // The tail follows every push
  always_ff @(posedge clk) begin
    if (head_load) begin
      head_q <= head_next;
    end
    if (push_sel) begin
      tail_q <= push_ptr;
    end
  end

  // Chain the new pointer behind the current tail
  // Nothing to link when the sub-list is empty
  // An idle sub-list drives all zeros so the writes merge with an OR
  always_comb begin
    ram_wr = '0;
    if (push_sel && !is_empty) begin
      ram_wr = '{valid: 1'b1, addr: tail_q, data: push_ptr};
    end
  end

  assign head    = head_q;
  assign head_ok = head_valid_q && !is_empty;
  assign count   = count_q;

  // Popping this entry leaves nothing behind, so no RAM read is needed
  assign last = (count_q == ll_cnt_t'(1)) && !push_sel;

endmodule

`default_nettype wire

// ==== verilog/ll_list_steer.sv ====
////////////////////
// Selects are one-hot and start at sub-list 0 after reset
// Head bandwidth is NumLists pops per RamReadLatency + 1 cycles
////////////////////

`timescale 1ns/1ns
`default_nettype none

module ll_list_steer import ll_pkg::*; #(
  parameter int NumLists       = 2,
  parameter int RamReadLatency = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_valid,
  input  logic                   head_ready,
  input  ll_ptr_t [NumLists-1:0] sub_head,
  input  logic [NumLists-1:0]    sub_head_ok,
  input  logic [NumLists-1:0]    sub_last,
  input  ll_cnt_t [NumLists-1:0] sub_count,
  output logic [NumLists-1:0]    push_sel,
  output logic [NumLists-1:0]    pop_sel,
  output logic [NumLists-1:0]    rsp_sel,
  output ll_ram_rd_req_t         rd_req,
  output logic                   head_valid,
  output ll_ptr_t                head,
  output logic                   empty,
  output ll_cnt_t                items
);

  typedef logic [NumLists-1:0] sel_t;

  sel_t tail_sel_q;
  sel_t head_sel_q;
  sel_t tail_sel_rot;
  sel_t head_sel_rot;
  logic pop;
  logic rd_needed;
  logic rsp_valid;
  sel_t rsp_data;

  // Rotate each select left by one position, wrapping the top bit to bit 0
  always_comb begin
    for (int i = 0; i < NumLists; i++) begin
      tail_sel_rot[i] = tail_sel_q[(i + NumLists - 1) % NumLists];
      head_sel_rot[i] = head_sel_q[(i + NumLists - 1) % NumLists];
    end
  end

  // Tail select advances on every push, head select on every pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tail_sel_q <= sel_t'(1);
      head_sel_q <= sel_t'(1);
    end else begin
      if (push_valid) begin
        tail_sel_q <= tail_sel_rot;
      end
      if (pop) begin
        head_sel_q <= head_sel_rot;
      end
    end
  end

  // Head port shows whatever the head select currently points at
  always_comb begin
    head = '0;
    for (int i = 0; i < NumLists; i++) begin
      if (head_sel_q[i]) begin
        head = sub_head[i];
      end
    end
  end

  assign head_valid = |(head_sel_q & sub_head_ok);
  assign pop        = head_valid && head_ready;

  assign push_sel = tail_sel_q & {NumLists{push_valid}};
  assign pop_sel  = head_sel_q & {NumLists{pop}};

  // A popped sub-list that keeps entries needs its next head from the RAM
  assign rd_needed = ~|(head_sel_q & sub_last);
  assign rd_req    = '{valid: pop && rd_needed, addr: head};

  // The head select follows the read so the return reaches the right sub-list
  ll_delay_line #(
    .Stages    (RamReadLatency),
    .payload_t (sel_t)
  ) sel_delay_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (rd_req.valid),
    .in_data   (head_sel_q),
    .out_valid (rsp_valid),
    .out_data  (rsp_data)
  );

  assign rsp_sel = rsp_data & {NumLists{rsp_valid}};

  // Total never exceeds the depth, so the count width is enough
  always_comb begin
    items = '0;
    for (int i = 0; i < NumLists; i++) begin
      items = items + sub_count[i];
    end
  end

  assign empty = (items == '0);

endmodule

`default_nettype wire

// ==== verilog/ll_ctrl_top.sv ====
////////////////////
// push_ptr must not already be in the list; pushes have no back-pressure
// NumLists from 1 to 4, RamReadLatency from 0 to 3
////////////////////

`timescale 1ns/1ns
`default_nettype none

module ll_ctrl_top import ll_pkg::*; #(
  parameter int NumLists       = 2,
  parameter int RamReadLatency = 2
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    push_valid,
  input  ll_ptr_t push_ptr,
  output logic    head_valid,
  input  logic    head_ready,
  output ll_ptr_t head,
  output logic    empty,
  output ll_cnt_t items
);

  logic [NumLists-1:0]    push_sel;
  logic [NumLists-1:0]    pop_sel;
  logic [NumLists-1:0]    rsp_sel;
  ll_ptr_t [NumLists-1:0] sub_head;
  logic [NumLists-1:0]    sub_head_ok;
  logic [NumLists-1:0]    sub_last;
  ll_cnt_t [NumLists-1:0] sub_count;
  ll_ram_wr_t [NumLists-1:0] sub_wr;
  ll_ram_wr_t     ram_wr;
  ll_ram_rd_req_t rd_req;
  ll_ram_rd_rsp_t rd_rsp;

  // Round-robin steering across the sub-lists and the head port
  ll_list_steer #(
    .NumLists       (NumLists),
    .RamReadLatency (RamReadLatency)
  ) steer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .head_ready  (head_ready),
    .sub_head    (sub_head),
    .sub_head_ok (sub_head_ok),
    .sub_last    (sub_last),
    .sub_count   (sub_count),
    .push_sel    (push_sel),
    .pop_sel     (pop_sel),
    .rsp_sel     (rsp_sel),
    .rd_req      (rd_req),
    .head_valid  (head_valid),
    .head        (head),
    .empty       (empty),
    .items       (items)
  );

  for (genvar i = 0; i < NumLists; i++) begin : gen_sublist
    ll_sublist sublist_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .push_sel (push_sel[i]),
      .push_ptr (push_ptr),
      .pop_sel  (pop_sel[i]),
      .rsp_sel  (rsp_sel[i]),
      .rd_rsp   (rd_rsp),
      .head     (sub_head[i]),
      .head_ok  (sub_head_ok[i]),
      .last     (sub_last[i]),
      .count    (sub_count[i]),
      .ram_wr   (sub_wr[i])
    );
  end

  // At most one sub-list writes per cycle, so an OR is enough to merge them
  always_comb begin
    ram_wr = '0;
    for (int i = 0; i < NumLists; i++) begin
      ram_wr = ram_wr | sub_wr[i];
    end
  end

  ll_ptr_ram #(
    .RamReadLatency (RamReadLatency)
  ) ram_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr     (ram_wr),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

endmodule

`default_nettype wire

// ==== bench/ll_ctrl_props.sv ====
////////////////////
// Bound to ll_ctrl_top, checks head port and item count rules
// Checks are disabled while reset is asserted
////////////////////

`timescale 1ns/1ns
`default_nettype none

module ll_ctrl_props import ll_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    push_valid,
  input logic    head_valid,
  input logic    head_ready,
  input ll_ptr_t head,
  input logic    empty,
  input ll_cnt_t items
);

  // An empty list can never offer a head
  a_empty_no_head: assert property (@(posedge clk) disable iff (!rst_n)
    empty |-> !head_valid)
    else $error("head_valid high while the list is empty");

  // Item count moves only by the push and the pop of the previous cycle
  a_items_step: assert property (@(posedge clk) disable iff (!rst_n)
    items == ll_cnt_t'($past(items) + $past(push_valid)
                       - $past(head_valid && head_ready)))
    else $error("items does not follow pushes and pops");

  // A stalled head must stay offered and unchanged
  a_head_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (head_valid && !head_ready) |=> (head_valid && $stable(head)))
    else $error("head changed while stalled");

endmodule

bind ll_ctrl_top ll_ctrl_props props_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .push_valid (push_valid),
  .head_valid (head_valid),
  .head_ready (head_ready),
  .head       (head),
  .empty      (empty),
  .items      (items)
);

`default_nettype wire

// ==== bench/tb_ll_ctrl.sv ====
////////////////////
// Runs with NumLists 2 and RamReadLatency 2
// Pushed pointers come from a pool of all 32, so none is in the list twice
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_ll_ctrl import ll_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RAND_CYCLES  = 400;
  localparam int BP_CYCLES    = 300;
  localparam int DRAIN_LIMIT  = 200;
  localparam int TOTAL_CYCLES = 6 * DRAIN_LIMIT + RAND_CYCLES + BP_CYCLES + 50;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    push_valid;
  ll_ptr_t push_ptr;
  logic    head_ready;
  logic    head_valid;
  ll_ptr_t head;
  logic    empty;
  ll_cnt_t items;

  ll_ptr_t ref_q[$];
  ll_ptr_t pool[$];
  ll_ptr_t last_pushed;
  ll_ptr_t hold_head;
  logic    hold_seen = 1'b0;
  int      push_count = 0;
  int      pop_count = 0;
  int      err_count = 0;
  int      tests_run = 0;
  int      tests_failed = 0;

  ll_ctrl_top #(.NumLists(2), .RamReadLatency(2)) dut_i (
    .clk (clk), .rst_n (rst_n), .push_valid (push_valid), .push_ptr (push_ptr),
    .head_valid (head_valid), .head_ready (head_ready), .head (head),
    .empty (empty), .items (items)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // The oldest unpopped pointer is the head and the count is the net traffic
  function automatic ll_ptr_t exp_head();
    return ref_q[0];
  endfunction

  function automatic int exp_items();
    return push_count - pop_count;
  endfunction

  // Every pointer must be back in the pool exactly once
  function automatic bit pool_complete();
    bit [LL_DEPTH-1:0] seen;
    seen = '0;
    foreach (pool[i]) seen[pool[i]] = 1'b1;
    return (pool.size() == LL_DEPTH) && (&seen);
  endfunction

  task automatic report_mismatch(input string sig, input int got, input int exp);
    err_count++;
    $display("FAIL t=%0t %s: got %0d expected %0d", $time, sig, got, exp);
  endtask

  task automatic report_problem(input string what);
    err_count++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  // Outputs are compared at the falling edge, where they are settled
  // Whatever handshake is visible now takes effect at the next rising edge
  // Popped pointers go back to the pool as the DUT returned them
  always @(negedge clk) begin
    if (rst_n) begin
      if (int'(items) != exp_items()) report_mismatch("items", int'(items), exp_items());
      if (empty != (exp_items() == 0)) report_mismatch("empty", empty, exp_items() == 0);
      if (hold_seen && !(head_valid && head == hold_head)) begin
        report_problem("head dropped or changed while head_ready was low");
      end
      if (head_valid) begin
        if (ref_q.size() == 0) report_problem("head_valid high with nothing pushed");
        else if (head != exp_head()) report_mismatch("head", head, exp_head());
      end
      hold_seen = head_valid && !head_ready;
      hold_head = head;
      if (head_valid && head_ready && ref_q.size() != 0) begin
        ref_q.delete(0);
        pool.push_back(head);
        pop_count++;
      end
      if (push_valid) begin
        ref_q.push_back(push_ptr);
        push_count++;
      end
    end
  end

  // One clock of stimulus where a push takes a random pointer out of the pool
  task automatic drive_cycle(input bit want_push, input bit ready);
    int unsigned idx;
    @(posedge clk);
    if (want_push && pool.size() != 0) begin
      idx = $urandom % pool.size();
      last_pushed = pool[idx];
      pool.delete(idx);
      push_valid <= 1'b1;
      push_ptr   <= last_pushed;
    end else begin
      push_valid <= 1'b0;
    end
    head_ready <= ready;
  endtask

  // Pop until the model is empty, then every pointer must be back in the pool
  task automatic drain_list();
    int n;
    n = 0;
    while (ref_q.size() != 0 && n < DRAIN_LIMIT) begin
      drive_cycle(1'b0, 1'b1);
      n++;
    end
    drive_cycle(1'b0, 1'b0);
    if (ref_q.size() != 0) report_problem("list did not drain in time");
    if (!pool_complete()) report_problem("pointer lost or duplicated after drain");
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("test %-14s failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic test_reset();
    int errs;
    errs = err_count;
    @(negedge clk);
    if (empty !== 1'b1) report_mismatch("empty", empty, 1);
    if (items !== '0) report_mismatch("items", int'(items), 0);
    if (head_valid !== 1'b0) report_mismatch("head_valid", head_valid, 0);
    close_test("reset", errs);
  endtask

  task automatic test_order();
    int errs;
    int pops_before;
    errs = err_count;
    pops_before = pop_count;
    for (int i = 0; i < 10; i++) drive_cycle(1'b1, 1'b0);
    drain_list();
    if (pop_count - pops_before != 10) report_mismatch("pops", pop_count - pops_before, 10);
    close_test("order", errs);
  endtask

  task automatic test_concurrent();
    int errs;
    errs = err_count;
    for (int i = 0; i < RAND_CYCLES; i++) drive_cycle($urandom % 2 == 0, $urandom % 4 != 0);
    drain_list();
    close_test("concurrent", errs);
  endtask

  // Stalls last 1 to 8 cycles while pushes keep going underneath
  task automatic test_backpressure();
    int errs;
    int stall_left;
    errs = err_count;
    stall_left = 0;
    for (int i = 0; i < BP_CYCLES; i++) begin
      if (stall_left == 0 && $urandom % 4 == 0) stall_left = 1 + $urandom % 8;
      drive_cycle($urandom % 2 == 0, stall_left == 0);
      if (stall_left != 0) stall_left--;
    end
    drain_list();
    close_test("backpressure", errs);
  endtask

  task automatic test_refill();
    int errs;
    int n;
    ll_ptr_t first;
    errs = err_count;
    drain_list();
    drive_cycle(1'b1, 1'b0);
    first = last_pushed;
    for (int i = 0; i < 5; i++) drive_cycle(1'b1, 1'b0);
    drive_cycle(1'b0, 1'b0);
    n = 0;
    @(negedge clk);
    while (!head_valid && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!head_valid) report_problem("no head offered after refill");
    else if (head != first) report_mismatch("head", head, first);
    drain_list();
    close_test("drain_refill", errs);
  endtask

  initial begin
    rst_n      = 1'b0;
    push_valid = 1'b0;
    push_ptr   = '0;
    head_ready = 1'b0;
    void'($urandom(32'h7a0e_8227));
    for (int i = 0; i < LL_DEPTH; i++) pool.push_back(ll_ptr_t'(i));
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_order();
    test_concurrent();
    test_backpressure();
    test_refill();
    repeat (2) @(posedge clk);
    $display("%0d tests run, %0d failed, %0d errors, %0d pushes, %0d pops",
             tests_run, tests_failed, err_count, push_count, pop_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Twice the longest expected run before giving up
  initial begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/ll_pkg.sv
verilog/ll_delay_line.sv
verilog/ll_ptr_ram.sv
verilog/ll_sublist.sv
verilog/ll_list_steer.sv
verilog/ll_ctrl_top.sv
bench/ll_ctrl_props.sv
bench/tb_ll_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the linked-list controller testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_ll_ctrl -o sim_ll_ctrl

# The simulator status is not trusted alone, the log decides
./obj_dir/sim_ll_ctrl | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
